//--- verilog/zports_pkg.sv
// port addresses, extended register indices, reset values and data byte types
package zports_pkg;

  typedef logic [7:0] zbyte_t;

  // low address byte of the i/o ports
  localparam zbyte_t port_fe     = 8'hFE;
  localparam zbyte_t port_fd     = 8'hFD;  // 7FFD paging and AY
  localparam zbyte_t port_xt     = 8'hAF;  // #nnAF extended registers
  localparam zbyte_t port_kjoy   = 8'h1F;
  localparam zbyte_t port_kmouse = 8'hDF;
  localparam zbyte_t port_sdcfg  = 8'h77;
  localparam zbyte_t port_sddat  = 8'h57;

  // VG93 ports, visible in dos only
  localparam zbyte_t vg_com = 8'h1F;
  localparam zbyte_t vg_trk = 8'h3F;
  localparam zbyte_t vg_sec = 8'h5F;
  localparam zbyte_t vg_dat = 8'h7F;
  localparam zbyte_t vg_sys = 8'hFF;

  // extended register index, high address byte of #nnAF
  localparam zbyte_t xr_stat      = 8'h00;
  localparam zbyte_t xr_rampage   = 8'h10;  // four pages, 10..13
  localparam zbyte_t xr_fmaddr    = 8'h15;
  localparam zbyte_t xr_sysconf   = 8'h20;
  localparam zbyte_t xr_memconf   = 8'h21;
  localparam zbyte_t xr_dmastat   = 8'h27;
  localparam zbyte_t xr_fddvirt   = 8'h29;
  localparam zbyte_t xr_intmask   = 8'h2A;
  localparam zbyte_t xr_cacheconf = 8'h2B;

  // register values after reset
  localparam zbyte_t rampage_rst0 = 8'h00;
  localparam zbyte_t rampage_rst1 = 8'h05;
  localparam zbyte_t rampage_rst2 = 8'h02;
  localparam zbyte_t rampage_rst3 = 8'h00;
  localparam zbyte_t memconf_rst  = 8'h04;  // rom mapping off
  localparam zbyte_t sysconf_rst  = 8'h00;  // 3.5 MHz
  localparam zbyte_t intmask_rst  = 8'h01;  // frame interrupt only

  // layout of a byte written to 7FFD
  typedef struct packed {
    logic [1:0] bank_hi;
    logic       lock48;
    logic       rom;
    logic       screen;
    logic [2:0] bank_lo;
  } p7ffd_t;

  // one data bus byte, plain or as 7FFD fields
  typedef union packed {
    zbyte_t raw;
    p7ffd_t p7ffd;
  } zdata_u;

endpackage

//--- verilog/port_decode.sv
// port address decoder with port hits, AY strobes, register file and 7FFD strobes
`timescale 1ns/1ps

module port_decode (
  input  logic               [15:0] a,
  input  logic                      regs_we,
  input  logic                      iord,
  input  logic                      iowr,
  input  logic                      iordwr,
  input  logic                      iord_s,
  input  logic                      iowr_s,
  input  logic                      dos,
  input  logic                      vdos,
  input  logic                      open_vg,
  output logic                      porthit,
  output logic                      external_port,
  output logic                      dataout,
  output logic                      ay_bdir,
  output logic                      ay_bc1,
  output logic                      xt_wr,
  output logic                      xt_rd,
  output zports_pkg::zbyte_t        xt_index,
  output logic                      p7ffd_wr_req,
  output logic                      vg_hit,
  output logic                      vgsys_hit,
  output logic                      sdcfg_hit,
  output logic                      sddat_hit
);
  import zports_pkg::*;

  zbyte_t loa;
  logic   vg_open;   // VG93 ports mapped in
  logic   sd_open;   // Z-controller ports mapped in
  logic   ay_hit;
  logic   xt_hit;

  assign loa = a[7:0];

  // raw address matches before gating
  assign vg_hit    = (loa == vg_com) || (loa == vg_trk) || (loa == vg_sec) || (loa == vg_dat);
  assign vgsys_hit = (loa == vg_sys);
  assign sdcfg_hit = (loa == port_sdcfg);
  assign sddat_hit = (loa == port_sddat);
  assign xt_hit    = (loa == port_xt);

  assign vg_open = dos || open_vg;
  assign sd_open = !dos || vdos;
  assign ay_hit  = (loa == port_fd) && a[15];  // FFFD / BFFD

  // joystick shares 1F with the VG command port
  assign porthit = (loa == port_fe) || xt_hit || (loa == port_fd)
                || ((vg_hit || vgsys_hit) && vg_open)
                || ((loa == port_kjoy) && !vg_open)
                || (loa == port_kmouse)
                || ((sdcfg_hit || sddat_hit) && sd_open);

  assign external_port = ay_hit || (vg_hit && vg_open);
  assign dataout       = porthit && iord && !external_port;

  assign ay_bc1  = ay_hit && a[14] && iordwr;
  assign ay_bdir = ay_hit && iowr;

  // regs_we carries the index on the low byte
  assign xt_index = regs_we ? a[7:0] : a[15:8];
  assign xt_wr    = (xt_hit && iowr_s) || regs_we;
  assign xt_rd    = xt_hit && iord_s;

  assign p7ffd_wr_req = !a[15] && (loa == port_fd) && iowr_s;  // lock48 applied downstream

  // the bus driver only turns on in a read cycle
  always_comb
  begin
    if (dataout)
      assert (!iowr)
        else $error("dataout raised during a write cycle");
  end

endmodule

//--- verilog/ext_regs.sv
// extended register file: RAM pages, config bytes, 7FFD paging with locks, power-up flag
`timescale 1ns/1ps

module ext_regs (
  input  logic                      clk,
  input  logic                      rst,
  input  zports_pkg::zbyte_t        din,
  input  logic                      opfetch,
  input  logic                      xt_wr,
  input  logic                      xt_rd,
  input  zports_pkg::zbyte_t        xt_index,
  input  logic                      p7ffd_wr_req,
  input  logic                      dma_act,
  output logic               [31:0] xt_page,
  output logic                [4:0] fmaddr,
  output zports_pkg::zbyte_t        sysconf,
  output zports_pkg::zbyte_t        memconf,
  output logic                [3:0] cacheconf,
  output zports_pkg::zbyte_t        fddvirt,
  output zports_pkg::zbyte_t        intmask,
  output zports_pkg::zbyte_t        xt_rd_data
);
  import zports_pkg::*;

  zbyte_t     rampage [0:3];
  zdata_u     din_u;
  logic       lock48;
  logic       pwr_up;
  logic       m1_lock128;  // opcode test for lock128 mode 2
  logic [1:0] lock_mode;
  logic       lock128;
  logic       p7ffd_wr;
  logic [2:0] bank3;
  zbyte_t     page3_next;

  assign din_u.raw = din;
  assign xt_page   = {rampage[3], rampage[2], rampage[1], rampage[0]};

  assign p7ffd_wr  = p7ffd_wr_req && !lock48;
  assign lock_mode = memconf[7:6];
  assign lock128   = (lock_mode == 2'b10) ? m1_lock128 : memconf[6];

  always_ff @(posedge clk)
  begin
    if (opfetch)
      m1_lock128 <= (din[7] == din[6]);
  end

  // bank bits 5:3 of page 3 per lock128 mode
  always_comb
  begin
    if (lock_mode == 2'b11)
      bank3 = {din_u.p7ffd.lock48, din_u.p7ffd.bank_hi};  // 1M mode
    else if (lock128)
      bank3 = 3'b000;
    else
      bank3 = {1'b0, din_u.p7ffd.bank_hi};
  end

  assign page3_next = {2'b00, bank3, din_u.p7ffd.bank_lo};

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rampage[0] <= rampage_rst0;
      rampage[1] <= rampage_rst1;
      rampage[2] <= rampage_rst2;
      rampage[3] <= rampage_rst3;
      fmaddr     <= 5'd0;
      sysconf    <= sysconf_rst;
      memconf    <= memconf_rst;
      cacheconf  <= 4'h0;
      fddvirt    <= 8'h00;
      intmask    <= intmask_rst;
    end
    else if (p7ffd_wr)
    begin
      memconf[0] <= din_u.p7ffd.rom;
      rampage[3] <= page3_next;
    end
    else if (xt_wr)
    begin
      if (xt_index[7:2] == xr_rampage[7:2])
        rampage[xt_index[1:0]] <= din_u.raw;
      if (xt_index == xr_fmaddr)
        fmaddr <= din_u.raw[4:0];
      if (xt_index == xr_sysconf)
      begin
        sysconf   <= din_u.raw;
        cacheconf <= {4{din_u.raw[2]}};  // cache follows the turbo bit
      end
      if (xt_index == xr_cacheconf)
        cacheconf <= din_u.raw[3:0];
      if (xt_index == xr_memconf)
        memconf <= din_u.raw;
      if (xt_index == xr_fddvirt)
        fddvirt <= din_u.raw;
      if (xt_index == xr_intmask)
        intmask <= din_u.raw;
    end
  end

  // lock48 is frozen in mode 3, bit 5 is a bank bit there
  always_ff @(posedge clk)
  begin
    if (rst)
      lock48 <= 1'b0;
    else if (p7ffd_wr && (lock_mode != 2'b11))
      lock48 <= din_u.p7ffd.lock48;
  end

  // cleared by the first status read
  always_ff @(posedge clk)
  begin
    if (rst)
      pwr_up <= 1'b1;
    else if (xt_rd && (xt_index == xr_stat))
      pwr_up <= 1'b0;
  end

  always_comb
  begin
    case (xt_index)
      xr_stat:                        xt_rd_data = {1'b0, pwr_up, 6'b000000};
      xr_dmastat:                     xt_rd_data = {dma_act, 7'b0000000};
      xr_rampage + 8'd2,
      xr_rampage + 8'd3:              xt_rd_data = rampage[xt_index[1:0]];
      default:                        xt_rd_data = 8'hFF;
    endcase
  end

  // decoder must not issue both kinds of page write at once
  assert property (@(posedge clk) disable iff (rst) !(xt_wr && p7ffd_wr))
    else $error("register file write collides with a 7FFD write");

endmodule

//--- verilog/disk_ports.sv
// VG93 floppy control with virtual drives, and Z-controller SD card port
`timescale 1ns/1ps

module disk_ports (
  input  logic                      clk,
  input  logic                      rst,
  input  zports_pkg::zbyte_t        din,
  input  logic                      iordwr,
  input  logic                      iord_s,
  input  logic                      iowr_s,
  input  logic                      iordwr_s,
  input  logic                      wr,
  input  logic                      dos,
  input  logic                      vdos,
  input  logic                      cfg_floppy_swap,
  input  zports_pkg::zbyte_t        fddvirt,
  input  logic                      vg_hit,
  input  logic                      vgsys_hit,
  input  logic                      sdcfg_hit,
  input  logic                      sddat_hit,
  output logic                      open_vg,
  output logic                [1:0] drive_sel,
  output logic                      vg_cs_n,
  output logic                      vg_wr_ff,
  output logic                      vdos_on,
  output logic                      vdos_off,
  output logic                      sdcs_n,
  output logic                      sd_start,
  output zports_pkg::zbyte_t        sd_datain
);
  import zports_pkg::*;

  logic [1:0] drive_sel_raw;
  logic       virt_vg;
  logic       vg_open;
  logic       vg_wen;    // real VG93 may be accessed
  logic       sd_open;

  assign open_vg = fddvirt[7];              // VG ports visible outside dos
  assign vg_open = dos || open_vg;
  assign virt_vg = fddvirt[drive_sel_raw];  // indexed by the unswapped number

  assign drive_sel = {drive_sel_raw[1], drive_sel_raw[0] ^ cfg_floppy_swap};

  assign vg_wen   = vg_open && !vdos && !virt_vg;
  assign vg_cs_n  = !(iordwr && vg_hit && vg_wen);
  assign vg_wr_ff = iowr_s && vgsys_hit && vg_wen;

  // virtual drive traps into vdos and any VG access there leaves it
  assign vdos_on  = iordwr_s && (vg_hit || vgsys_hit) && dos && !vdos && virt_vg;
  assign vdos_off = iordwr_s && vg_hit && vdos;

  always_ff @(posedge clk)
  begin
    if (rst)
      drive_sel_raw <= 2'b00;
    else if (iowr_s && vgsys_hit && vg_open)
      drive_sel_raw <= din[1:0];
  end

  assign sd_open = !dos || vdos;

  always_ff @(posedge clk)
  begin
    if (rst)
      sdcs_n <= 1'b1;  // card deselected
    else if (sdcfg_hit && iowr_s && sd_open)
      sdcs_n <= din[1];
  end

  // every data port access starts one SPI byte
  assign sd_start  = (sddat_hit && iowr_s && sd_open) || (sddat_hit && iord_s);
  assign sd_datain = wr ? din : 8'hFF;  // reads shift out ones

  // vdos traps use the strobe while the VG93 select uses the level
  assert property (@(posedge clk) disable iff (rst) iordwr_s |-> iordwr)
    else $error("iordwr_s strobe outside an iordwr cycle");

endmodule

//--- verilog/port_read_mux.sv
// read data multiplexer for the readable i/o ports
`timescale 1ns/1ps

module port_read_mux (
  input  logic               [7:0] a,          // low address byte
  input  zports_pkg::zbyte_t       xt_rd_data,
  input  logic                     tape_read,
  input  logic               [4:0] keys_in,
  input  logic               [4:0] kj_in,
  input  zports_pkg::zbyte_t       mus_in,
  input  logic                     vg_intrq,
  input  logic                     vg_drq,
  input  zports_pkg::zbyte_t       sd_dataout,
  output zports_pkg::zbyte_t       dout
);
  import zports_pkg::*;

  // dos gating of 1F is done by dataout, here 1F is always the joystick
  always_comb
  begin
    case (a)
      port_fe:
        dout = {1'b1, tape_read, 1'b0, keys_in};
      port_xt:
        dout = xt_rd_data;
      vg_sys:
        dout = {vg_intrq, vg_drq, 6'b111111};
      port_kjoy:
        dout = {3'b000, kj_in};
      port_kmouse:
        dout = mus_in;
      port_sdcfg:
        dout = 8'h00;        // card present, not write protected
      port_sddat:
        dout = sd_dataout;
      default:
        dout = 8'hFF;
    endcase
  end

endmodule

//--- verilog/zports_top.sv
// zports top level: decoder, register file, disk ports and read mux
`timescale 1ns/1ps

module zports_top (
  input  logic                      clk,
  input  logic                      rst,
  input  logic               [15:0] a,
  input  zports_pkg::zbyte_t        din,
  input  logic                      iord,
  input  logic                      iowr,
  input  logic                      iordwr,
  input  logic                      iord_s,
  input  logic                      iowr_s,
  input  logic                      iordwr_s,
  input  logic                      wr,
  input  logic                      opfetch,
  input  logic                      regs_we,
  input  logic                      dos,
  input  logic                      vdos,
  input  logic                      tape_read,
  input  logic                [4:0] keys_in,
  input  logic                [4:0] kj_in,
  input  zports_pkg::zbyte_t        mus_in,
  input  logic                      vg_intrq,
  input  logic                      vg_drq,
  input  logic                      dma_act,
  input  logic                      cfg_floppy_swap,
  input  zports_pkg::zbyte_t        sd_dataout,
  output zports_pkg::zbyte_t        dout,
  output logic                      dataout,
  output logic                      porthit,
  output logic                      external_port,
  output logic                      ay_bdir,
  output logic                      ay_bc1,
  output logic               [31:0] xt_page,
  output logic                [4:0] fmaddr,
  output zports_pkg::zbyte_t        sysconf,
  output zports_pkg::zbyte_t        memconf,
  output logic                [3:0] cacheconf,
  output zports_pkg::zbyte_t        fddvirt,
  output zports_pkg::zbyte_t        intmask,
  output logic                [1:0] drive_sel,
  output logic                      vg_cs_n,
  output logic                      vg_wr_ff,
  output logic                      vdos_on,
  output logic                      vdos_off,
  output logic                      sdcs_n,
  output logic                      sd_start,
  output zports_pkg::zbyte_t        sd_datain
);
  import zports_pkg::*;

  logic   xt_wr;
  logic   xt_rd;
  zbyte_t xt_index;
  zbyte_t xt_rd_data;
  logic   p7ffd_wr_req;
  logic   vg_hit;
  logic   vgsys_hit;
  logic   sdcfg_hit;
  logic   sddat_hit;
  logic   open_vg;

  port_decode u_decode (
    .a             (a),
    .regs_we       (regs_we),
    .iord          (iord),
    .iowr          (iowr),
    .iordwr        (iordwr),
    .iord_s        (iord_s),
    .iowr_s        (iowr_s),
    .dos           (dos),
    .vdos          (vdos),
    .open_vg       (open_vg),
    .porthit       (porthit),
    .external_port (external_port),
    .dataout       (dataout),
    .ay_bdir       (ay_bdir),
    .ay_bc1        (ay_bc1),
    .xt_wr         (xt_wr),
    .xt_rd         (xt_rd),
    .xt_index      (xt_index),
    .p7ffd_wr_req  (p7ffd_wr_req),
    .vg_hit        (vg_hit),
    .vgsys_hit     (vgsys_hit),
    .sdcfg_hit     (sdcfg_hit),
    .sddat_hit     (sddat_hit)
  );

  ext_regs u_regs (
    .clk          (clk),
    .rst          (rst),
    .din          (din),
    .opfetch      (opfetch),
    .xt_wr        (xt_wr),
    .xt_rd        (xt_rd),
    .xt_index     (xt_index),
    .p7ffd_wr_req (p7ffd_wr_req),
    .dma_act      (dma_act),
    .xt_page      (xt_page),
    .fmaddr       (fmaddr),
    .sysconf      (sysconf),
    .memconf      (memconf),
    .cacheconf    (cacheconf),
    .fddvirt      (fddvirt),
    .intmask      (intmask),
    .xt_rd_data   (xt_rd_data)
  );

  disk_ports u_disk (
    .clk             (clk),
    .rst             (rst),
    .din             (din),
    .iordwr          (iordwr),
    .iord_s          (iord_s),
    .iowr_s          (iowr_s),
    .iordwr_s        (iordwr_s),
    .wr              (wr),
    .dos             (dos),
    .vdos            (vdos),
    .cfg_floppy_swap (cfg_floppy_swap),
    .fddvirt         (fddvirt),
    .vg_hit          (vg_hit),
    .vgsys_hit       (vgsys_hit),
    .sdcfg_hit       (sdcfg_hit),
    .sddat_hit       (sddat_hit),
    .open_vg         (open_vg),
    .drive_sel       (drive_sel),
    .vg_cs_n         (vg_cs_n),
    .vg_wr_ff        (vg_wr_ff),
    .vdos_on         (vdos_on),
    .vdos_off        (vdos_off),
    .sdcs_n          (sdcs_n),
    .sd_start        (sd_start),
    .sd_datain       (sd_datain)
  );

  port_read_mux u_rdmux (
    .a          (a[7:0]),
    .xt_rd_data (xt_rd_data),
    .tape_read  (tape_read),
    .keys_in    (keys_in),
    .kj_in      (kj_in),
    .mus_in     (mus_in),
    .vg_intrq   (vg_intrq),
    .vg_drq     (vg_drq),
    .sd_dataout (sd_dataout),
    .dout       (dout)
  );

endmodule

//--- verif/zports_tb.sv
// directed testbench for the zports I/O port block
`timescale 1ns/1ps

module zports_tb;

  localparam int clk_period  = 4;
  localparam int test_cycles = 100;  // reset plus all six tests rounded up
  localparam int margin_ns   = 100;

  logic        clk;
  logic        rst;
  logic [15:0] a;
  logic [7:0]  din;
  logic        iord;
  logic        iowr;
  logic        iordwr;
  logic        iord_s;
  logic        iowr_s;
  logic        iordwr_s;
  logic        wr;
  logic        opfetch;
  logic        regs_we;
  logic        dos;
  logic        vdos;
  logic        tape_read;
  logic [4:0]  keys_in;
  logic [4:0]  kj_in;
  logic [7:0]  mus_in;
  logic        vg_intrq;
  logic        vg_drq;
  logic        dma_act;
  logic        cfg_floppy_swap;
  logic [7:0]  sd_dataout;

  logic [7:0]  dout;
  logic        dataout;
  logic        porthit;
  logic        external_port;
  logic        ay_bdir;
  logic        ay_bc1;
  logic [31:0] xt_page;
  logic [4:0]  fmaddr;
  logic [7:0]  sysconf;
  logic [7:0]  memconf;
  logic [3:0]  cacheconf;
  logic [7:0]  fddvirt;
  logic [7:0]  intmask;
  logic [1:0]  drive_sel;
  logic        vg_cs_n;
  logic        vg_wr_ff;
  logic        vdos_on;
  logic        vdos_off;
  logic        sdcs_n;
  logic        sd_start;
  logic [7:0]  sd_datain;

  integer seed;
  integer errors;
  integer checks;
  integer case_errors;
  integer tests_run;
  integer tests_failed;

  zports_top u_dut (.*);

  always #(clk_period / 2) clk = ~clk;

  function logic [7:0] rand_byte();
    integer r;
    r = $random(seed);
    return r[7:0];
  endfunction

  task expect_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks = checks + 1;
    if (got !== exp)
    begin
      $display("** Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      errors = errors + 1;
      case_errors = case_errors + 1;
    end
  endtask

  task start_case();
    case_errors = 0;
    tests_run = tests_run + 1;
  endtask

  task report_case(input string name);
    if (case_errors == 0)
      $display("%s: pass", name);
    else
    begin
      $display("%s: fail, %0d errors", name, case_errors);
      tests_failed = tests_failed + 1;
    end
  endtask

  // one-cycle bus accesses driven on the falling edge
  task write_port(input logic [15:0] addr, input logic [7:0] data);
    @(negedge clk);
    a = addr;
    din = data;
    wr = 1'b1;
    iowr = 1'b1;
    iordwr = 1'b1;
    iowr_s = 1'b1;
    iordwr_s = 1'b1;
    #1;
  endtask

  task read_port(input logic [15:0] addr);
    @(negedge clk);
    a = addr;
    wr = 1'b0;
    iord = 1'b1;
    iordwr = 1'b1;
    iord_s = 1'b1;
    iordwr_s = 1'b1;
    #1;  // outputs settle well before the rising edge
  endtask

  task load_reg(input logic [7:0] idx, input logic [7:0] data);
    @(negedge clk);
    a = {8'h00, idx};  // index rides on the low byte
    din = data;
    regs_we = 1'b1;
    #1;
  endtask

  task release_bus();
    @(negedge clk);
    iord = 1'b0;
    iowr = 1'b0;
    iordwr = 1'b0;
    iord_s = 1'b0;
    iowr_s = 1'b0;
    iordwr_s = 1'b0;
    wr = 1'b0;
    regs_we = 1'b0;
    opfetch = 1'b0;
    #1;
  endtask

  task reset_values();
    start_case();
    @(negedge clk);
    #1;
    expect_value("xt_page", xt_page, 'h00020500);
    expect_value("memconf", 32'(memconf), 'h04);
    expect_value("sysconf", 32'(sysconf), 'h00);
    expect_value("cacheconf", 32'(cacheconf), 'h0);
    expect_value("intmask", 32'(intmask), 'h01);
    expect_value("sdcs_n", 32'(sdcs_n), 'h1);
    expect_value("drive_sel", 32'(drive_sel), 'h0);
    report_case("reset values");
  endtask

  task ext_reg_writes();
    logic [7:0] v;
    logic [7:0] pg [0:3];
    int         i;
    start_case();
    for (i = 0; i < 4; i++)
    begin
      pg[i] = rand_byte();
      write_port({6'b000100, 2'(i), 8'hAF}, pg[i]);  // #10AF..#13AF
      release_bus();
      expect_value("xt_page byte", 32'(xt_page[8*i +: 8]), 32'(pg[i]));
    end
    v = rand_byte();
    load_reg(8'h15, v);
    release_bus();
    expect_value("fmaddr", 32'(fmaddr), 32'(v[4:0]));
    v = rand_byte();
    load_reg(8'h29, v);
    release_bus();
    expect_value("fddvirt", 32'(fddvirt), 32'(v));
    v = rand_byte();
    load_reg(8'h2A, v);
    release_bus();
    expect_value("intmask", 32'(intmask), 32'(v));
    read_port(16'h12AF);
    expect_value("page 2 read", 32'(dout), 32'(pg[2]));
    release_bus();
    read_port(16'h13AF);
    expect_value("page 3 read", 32'(dout), 32'(pg[3]));
    release_bus();
    read_port(16'h3FAF);
    expect_value("unused index read", 32'(dout), 'hFF);
    release_bus();
    v = rand_byte() | 8'h04;
    write_port(16'h20AF, v);
    release_bus();
    expect_value("sysconf", 32'(sysconf), 32'(v));
    expect_value("cacheconf", 32'(cacheconf), 'hF);
    load_reg(8'h29, 8'h00);  // back to real drives with VG ports closed
    release_bus();
    report_case("extended register writes");
  endtask

  task paging_7ffd();
    logic [7:0] v;
    logic [7:0] page3;
    logic       rom;
    int         n;
    start_case();
    for (n = 0; n < 4; n++)
    begin
      v = rand_byte() & 8'hDF;  // lock48 field clear
      write_port(16'h7FFD, v);
      release_bus();
      page3 = {3'b000, v[7:6], v[2:0]};  // mode 0 gives zero then bank_hi and bank_lo
      expect_value("page 3 after 7FFD", 32'(xt_page[31:24]), 32'(page3));
      expect_value("memconf rom bit", 32'(memconf[0]), 32'(v[4]));
    end
    v = rand_byte() | 8'h20;
    write_port(16'h7FFD, v);
    release_bus();
    page3 = {3'b000, v[7:6], v[2:0]};
    rom = v[4];
    expect_value("page 3 with lock48", 32'(xt_page[31:24]), 32'(page3));
    write_port(16'h7FFD, ~v);
    release_bus();
    expect_value("page 3 while locked", 32'(xt_page[31:24]), 32'(page3));
    expect_value("memconf while locked", 32'(memconf[0]), 32'(rom));
    report_case("7FFD paging");
  endtask

  task read_path();
    logic [7:0] v;
    start_case();
    @(negedge clk);
    v = rand_byte();
    tape_read = v[5];
    keys_in = v[4:0];
    mus_in = rand_byte();
    v = rand_byte();
    kj_in = v[4:0];
    dos = 1'b0;
    read_port(16'h7FFE);
    expect_value("FE read", 32'(dout), 32'({1'b1, tape_read, 1'b0, keys_in}));
    expect_value("FE dataout", 32'(dataout), 'h1);
    expect_value("FE porthit", 32'(porthit), 'h1);
    release_bus();
    read_port(16'hFADF);
    expect_value("mouse read", 32'(dout), 32'(mus_in));
    release_bus();
    read_port(16'h001F);
    expect_value("joystick read", 32'(dout), 32'({3'b000, kj_in}));
    expect_value("joystick porthit", 32'(porthit), 'h1);
    release_bus();
    read_port(16'h0003);
    expect_value("unused porthit", 32'(porthit), 'h0);
    expect_value("unused read", 32'(dout), 'hFF);
    release_bus();
    read_port(16'hFFFD);
    expect_value("AY external_port", 32'(external_port), 'h1);
    expect_value("AY dataout", 32'(dataout), 'h0);
    expect_value("AY bc1", 32'(ay_bc1), 'h1);
    expect_value("AY bdir on read", 32'(ay_bdir), 'h0);
    release_bus();
    write_port(16'hBFFD, rand_byte());
    expect_value("AY bdir on write", 32'(ay_bdir), 'h1);
    expect_value("AY bc1 on data write", 32'(ay_bc1), 'h0);
    release_bus();
    report_case("read path and hits");
  endtask

  task status_flag();
    start_case();
    read_port(16'h00AF);
    expect_value("first status read", 32'(dout), 'h40);
    release_bus();
    read_port(16'h00AF);
    expect_value("second status read", 32'(dout), 'h00);
    release_bus();
    @(negedge clk);
    dma_act = 1'b1;
    read_port(16'h27AF);
    expect_value("DMA status read", 32'(dout), 'h80);
    release_bus();
    @(negedge clk);
    dma_act = 1'b0;
    report_case("status flag");
  endtask

  task disk_and_sd();
    logic [7:0] v;
    start_case();
    @(negedge clk);
    dos = 1'b1;
    vdos = 1'b0;
    cfg_floppy_swap = 1'b1;
    write_port(16'h00FF, 8'h02);
    expect_value("vg_wr_ff on real drive", 32'(vg_wr_ff), 'h1);
    release_bus();
    expect_value("drive_sel", 32'(drive_sel), 'h3);
    load_reg(8'h29, 8'h04);  // raw drive 2 becomes virtual
    release_bus();
    read_port(16'h003F);
    expect_value("vdos_on pulse", 32'(vdos_on), 'h1);
    expect_value("vg_cs_n on virtual drive", 32'(vg_cs_n), 'h1);
    release_bus();
    expect_value("vdos_on after access", 32'(vdos_on), 'h0);
    @(negedge clk);
    vdos = 1'b1;
    read_port(16'h003F);
    expect_value("vdos_off pulse", 32'(vdos_off), 'h1);
    expect_value("vdos_on under vdos", 32'(vdos_on), 'h0);
    release_bus();
    expect_value("vdos_off after access", 32'(vdos_off), 'h0);
    @(negedge clk);
    dos = 1'b0;
    vdos = 1'b0;
    cfg_floppy_swap = 1'b0;
    sd_dataout = rand_byte();
    v = rand_byte() & 8'hFD;
    write_port(16'h0077, v);
    release_bus();
    expect_value("sdcs_n", 32'(sdcs_n), 'h0);
    read_port(16'h0057);
    expect_value("sd_start on read", 32'(sd_start), 'h1);
    expect_value("sd_datain on read", 32'(sd_datain), 'hFF);
    expect_value("SD data read", 32'(dout), 32'(sd_dataout));
    release_bus();
    expect_value("sd_start after read", 32'(sd_start), 'h0);
    report_case("disk and SD control");
  endtask

  initial
  begin
    seed = 63064;
    errors = 0;
    checks = 0;
    case_errors = 0;
    tests_run = 0;
    tests_failed = 0;
    clk = 1'b0;
    rst = 1'b1;
    a = 16'h0000;
    din = 8'h00;
    iord = 1'b0;
    iowr = 1'b0;
    iordwr = 1'b0;
    iord_s = 1'b0;
    iowr_s = 1'b0;
    iordwr_s = 1'b0;
    wr = 1'b0;
    opfetch = 1'b0;
    regs_we = 1'b0;
    dos = 1'b0;
    vdos = 1'b0;
    tape_read = 1'b0;
    keys_in = 5'h1F;
    kj_in = 5'h00;
    mus_in = 8'hFF;
    vg_intrq = 1'b0;
    vg_drq = 1'b0;
    dma_act = 1'b0;
    cfg_floppy_swap = 1'b0;
    sd_dataout = 8'hFF;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    reset_values();
    ext_reg_writes();
    paging_7ffd();
    read_path();
    status_flag();
    disk_and_sd();
    $display("tests run %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

  // watchdog
  initial
  begin
    #(test_cycles * clk_period + margin_ns);
    $display("run timed out after %0d ns before the tests finished",
             test_cycles * clk_period + margin_ns);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

//--- zports.f
verilog/zports_pkg.sv
verilog/port_decode.sv
verilog/ext_regs.sv
verilog/disk_ports.sv
verilog/port_read_mux.sv
verilog/zports_top.sv
verif/zports_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the zports testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f zports.f --top-module zports_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vzports_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "TESTS PASSED"; then
  exit 0
else
  exit 1
fi
